// ==== rtl/dispatch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch package
// Data width, opcode encodings and the payload
// structs carried between the dispatch stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dispatch_pkg;

    localparam int unsigned XLEN = 32;

    typedef enum logic [1:0] {
        GRP_ALU  = 2'd0,
        GRP_BJP  = 2'd1,
        GRP_MEM  = 2'd2,
        GRP_NONE = 2'd3
    } disp_grp_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        LUI,   // Op1 forced to zero
        AUIPC, // Op1 taken from PC
        JUMP   // Link address PC + 4
    } alu_op_e;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } bjp_op_e;

    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } mem_op_e;

    // Decoded instruction from the decoder
    typedef struct packed {
        disp_grp_e         grp;
        logic [3:0]        sub_op;   // Meaning depends on grp
        logic              op2_imm;  // ALU op2 from immediate
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
    } disp_in_t;

    // Unit operands after the first stage
    typedef struct packed {
        logic              alu_req;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   alu_op1;
        logic [XLEN-1:0]   alu_op2;
        logic              bjp_req;
        bjp_op_e           bjp_op;
        logic [XLEN-1:0]   bjp_cmp1;
        logic [XLEN-1:0]   bjp_cmp2;
        logic [XLEN-1:0]   bjp_tgt1;
        logic [XLEN-1:0]   bjp_tgt2;
        logic              mem_req;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   mem_addr;
        logic [XLEN-1:0]   store_src;  // Raw rs2 for stores
    } operand_t;

    // Final dispatch packet
    typedef struct packed {
        logic              alu_req;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   alu_op1;
        logic [XLEN-1:0]   alu_op2;
        logic              bjp_req;
        bjp_op_e           bjp_op;
        logic [XLEN-1:0]   bjp_cmp1;
        logic [XLEN-1:0]   bjp_cmp2;
        logic [XLEN-1:0]   bjp_tgt1;
        logic [XLEN-1:0]   bjp_tgt2;
        logic              mem_req;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   mem_addr;
        logic [3:0]        mem_wmask;
        logic [XLEN-1:0]   mem_wdata;
        logic              misaligned_load;
        logic              misaligned_store;
    } disp_out_t;

endpackage

// ==== rtl/req_ack_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase receiver
// Takes a payload on req/ack and hands it to the
// pipeline as a valid/ready slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module req_ack_rx #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     req_i,
    input  payload_t data_i,
    output logic     ack_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    typedef enum logic {RX_IDLE, RX_ACKED} rx_phase_e;

    rx_phase_e phase_q;
    logic      full_q;
    payload_t  data_q;
    logic      capture;

    // New request, slot empty or draining this cycle
    assign capture = req_i && (phase_q == RX_IDLE) && (!full_q || ready_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q <= RX_IDLE;
            full_q  <= 1'b0;
        end else begin
            if (capture)
                phase_q <= RX_ACKED;
            else if (phase_q == RX_ACKED && !req_i)
                phase_q <= RX_IDLE;  // Requester released req
            if (capture)
                full_q <= 1'b1;
            else if (ready_i)
                full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) data_q <= data_i;
    end

    assign ack_o   = (phase_q == RX_ACKED);
    assign valid_o = full_q;
    assign data_o  = data_q;

endmodule

// ==== rtl/req_ack_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase sender
// Holds one payload and runs req/ack toward the
// execution units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module req_ack_tx #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     req_o,
    output payload_t data_o,
    input  logic     ack_i
);

    typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_ACK_LOW} tx_state_e;

    tx_state_e state_q;
    payload_t  data_q;

    // Idle only once both req and ack are low
    assign ready_o = (state_q == TX_IDLE) && !ack_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE:    if (valid_i && ready_o) state_q <= TX_REQ;
                TX_REQ:     if (ack_i) state_q <= TX_ACK_LOW;
                TX_ACK_LOW: if (!ack_i) state_q <= TX_IDLE;
                default:    state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) data_q <= data_i;
    end

    assign req_o  = (state_q == TX_REQ);
    assign data_o = data_q;

endmodule

// ==== rtl/operand_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand select stage
// Routes a decoded instruction to ALU, branch or
// memory operands and forms the effective address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_select (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,
    output logic                  ready_o,
    input  dispatch_pkg::disp_in_t in_i,
    output logic                  valid_o,
    input  logic                  ready_i,
    output dispatch_pkg::operand_t op_o
);

    dispatch_pkg::operand_t op_d;
    dispatch_pkg::operand_t op_q;
    dispatch_pkg::alu_op_e  alu_op;
    dispatch_pkg::bjp_op_e  bjp_op;
    logic                   valid_q;

    assign alu_op = dispatch_pkg::alu_op_e'(in_i.sub_op);
    assign bjp_op = dispatch_pkg::bjp_op_e'(in_i.sub_op[2:0]);

    always_comb begin
        op_d = '0;  // Unselected units stay zero
        case (in_i.grp)
            dispatch_pkg::GRP_ALU: begin
                op_d.alu_req = 1'b1;
                op_d.alu_op  = alu_op;
                if (alu_op == dispatch_pkg::AUIPC)
                    op_d.alu_op1 = in_i.pc;
                else if (alu_op == dispatch_pkg::LUI)
                    op_d.alu_op1 = '0;
                else
                    op_d.alu_op1 = in_i.rs1_data;
                op_d.alu_op2 = in_i.op2_imm ? in_i.imm : in_i.rs2_data;
            end
            dispatch_pkg::GRP_BJP: begin
                op_d.bjp_req  = 1'b1;
                op_d.bjp_op   = bjp_op;
                op_d.bjp_cmp1 = in_i.rs1_data;
                op_d.bjp_cmp2 = in_i.rs2_data;
                op_d.bjp_tgt1 = (bjp_op == dispatch_pkg::JALR) ? in_i.rs1_data : in_i.pc;
                op_d.bjp_tgt2 = in_i.imm;
                // Jumps also write the link register through the ALU
                if (bjp_op == dispatch_pkg::JAL || bjp_op == dispatch_pkg::JALR) begin
                    op_d.alu_req = 1'b1;
                    op_d.alu_op  = dispatch_pkg::JUMP;
                    op_d.alu_op1 = in_i.pc;
                    op_d.alu_op2 = dispatch_pkg::XLEN'(4);
                end
            end
            dispatch_pkg::GRP_MEM: begin
                op_d.mem_req   = 1'b1;
                op_d.mem_op    = dispatch_pkg::mem_op_e'(in_i.sub_op[2:0]);
                op_d.mem_addr  = in_i.rs1_data + in_i.imm;
                op_d.store_src = in_i.rs2_data;
            end
            default: ;
        endcase
    end

    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (ready_o)
            valid_q <= valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) op_q <= op_d;
    end

    assign valid_o = valid_q;
    assign op_o    = op_q;

endmodule

// ==== rtl/store_align.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store align stage
// Byte lane mask, lane-shifted store data and the
// misaligned access flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module store_align (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  dispatch_pkg::operand_t  op_i,
    output logic                   valid_o,
    input  logic                   ready_i,
    output dispatch_pkg::disp_out_t out_o
);

    dispatch_pkg::disp_out_t out_d;
    dispatch_pkg::disp_out_t out_q;
    logic [1:0]              addr_lo;
    logic                    valid_q;

    assign addr_lo = op_i.mem_addr[1:0];

    always_comb begin
        out_d = '0;
        out_d.alu_req  = op_i.alu_req;
        out_d.alu_op   = op_i.alu_op;
        out_d.alu_op1  = op_i.alu_op1;
        out_d.alu_op2  = op_i.alu_op2;
        out_d.bjp_req  = op_i.bjp_req;
        out_d.bjp_op   = op_i.bjp_op;
        out_d.bjp_cmp1 = op_i.bjp_cmp1;
        out_d.bjp_cmp2 = op_i.bjp_cmp2;
        out_d.bjp_tgt1 = op_i.bjp_tgt1;
        out_d.bjp_tgt2 = op_i.bjp_tgt2;
        out_d.mem_req  = op_i.mem_req;
        out_d.mem_op   = op_i.mem_op;
        out_d.mem_addr = op_i.mem_addr;
        if (op_i.mem_req) begin
            case (op_i.mem_op)
                dispatch_pkg::SB: begin
                    out_d.mem_wmask = 4'b0001 << addr_lo;
                    out_d.mem_wdata = {24'b0, op_i.store_src[7:0]} << {addr_lo, 3'b000};
                end
                dispatch_pkg::SH: begin
                    out_d.mem_wmask = addr_lo[1] ? 4'b1100 : 4'b0011;
                    out_d.mem_wdata = addr_lo[1] ? {op_i.store_src[15:0], 16'b0}
                                                 : {16'b0, op_i.store_src[15:0]};
                    out_d.misaligned_store = addr_lo[0];
                end
                dispatch_pkg::SW: begin
                    out_d.mem_wmask = 4'b1111;
                    out_d.mem_wdata = op_i.store_src;
                    out_d.misaligned_store = |addr_lo;
                end
                dispatch_pkg::LW: out_d.misaligned_load = |addr_lo;
                dispatch_pkg::LH,
                dispatch_pkg::LHU: out_d.misaligned_load = addr_lo[0];
                default: ;  // Byte loads always aligned
            endcase
        end
    end

    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (ready_o)
            valid_q <= valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) out_q <= out_d;
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

endmodule

// ==== rtl/dispatch_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch top
// Receiver, operand select, store align and sender
// chained as a four-stage pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  dispatch_pkg::disp_in_t  in_i,
    output logic                    ack_o,
    output logic                    disp_req_o,
    output dispatch_pkg::disp_out_t disp_o,
    input  logic                    disp_ack_i
);

    logic                    rx_valid, rx_ready;
    dispatch_pkg::disp_in_t  rx_data;
    logic                    sel_valid, sel_ready;
    dispatch_pkg::operand_t  sel_op;
    logic                    aln_valid, aln_ready;
    dispatch_pkg::disp_out_t aln_out;

    req_ack_rx #(.payload_t(dispatch_pkg::disp_in_t)) req_ack_rx_i (
        .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .data_i(in_i), .ack_o(ack_o),
        .valid_o(rx_valid), .data_o(rx_data), .ready_i(rx_ready)
    );

    operand_select operand_select_i (
        .clk_i(clk_i), .rst_i(rst_i), .valid_i(rx_valid), .ready_o(rx_ready),
        .in_i(rx_data), .valid_o(sel_valid), .ready_i(sel_ready), .op_o(sel_op)
    );

    store_align store_align_i (
        .clk_i(clk_i), .rst_i(rst_i), .valid_i(sel_valid), .ready_o(sel_ready),
        .op_i(sel_op), .valid_o(aln_valid), .ready_i(aln_ready), .out_o(aln_out)
    );

    // Downstream unit side
    req_ack_tx #(.payload_t(dispatch_pkg::disp_out_t)) req_ack_tx_i (
        .clk_i(clk_i), .rst_i(rst_i), .valid_i(aln_valid), .data_i(aln_out),
        .ready_o(aln_ready), .req_o(disp_req_o), .data_o(disp_o), .ack_i(disp_ack_i)
    );

endmodule

// ==== test/tb_dispatch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch testbench
// Four-phase driver and responder around the
// dispatch pipeline, checked against case file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dispatch;

    localparam int unsigned WAIT_LIMIT = 200;  // Cycles per handshake wait
    localparam int unsigned NUM_FIELDS = 24;

    logic                    clk;
    logic                    rst;
    logic                    req;
    logic                    ack;
    logic                    disp_req;
    logic                    disp_ack;
    dispatch_pkg::disp_in_t  in_pkt;
    dispatch_pkg::disp_out_t disp_pkt;

    dispatch_pkg::disp_in_t  stim_q[$];
    dispatch_pkg::disp_out_t exp_q[$];
    logic [31:0]             lfsr_state;
    int unsigned             case_idx;

    dispatch_top dispatch_top_i (
        .clk_i(clk), .rst_i(rst), .req_i(req), .in_i(in_pkt), .ack_o(ack),
        .disp_req_o(disp_req), .disp_o(disp_pkt), .disp_ack_i(disp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        $display("[FAIL] %s expected 0x%08h actual 0x%08h (case %0d)",
                 name, exp_v, act_v, case_idx);
        stop_run();
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout: %s within %0d cycles (case %0d)", what, WAIT_LIMIT, case_idx);
        stop_run();
    endtask

    task automatic check_alu(input dispatch_pkg::disp_out_t e, input dispatch_pkg::disp_out_t a);
        if (a.alu_req !== e.alu_req) value_error("disp_o.alu_req", e.alu_req, a.alu_req);
        if (a.alu_op !== e.alu_op) value_error("disp_o.alu_op", e.alu_op, a.alu_op);
        if (a.alu_op1 !== e.alu_op1) value_error("disp_o.alu_op1", e.alu_op1, a.alu_op1);
        if (a.alu_op2 !== e.alu_op2) value_error("disp_o.alu_op2", e.alu_op2, a.alu_op2);
    endtask

    task automatic check_bjp(input dispatch_pkg::disp_out_t e, input dispatch_pkg::disp_out_t a);
        if (a.bjp_req !== e.bjp_req) value_error("disp_o.bjp_req", e.bjp_req, a.bjp_req);
        if (a.bjp_op !== e.bjp_op) value_error("disp_o.bjp_op", e.bjp_op, a.bjp_op);
        if (a.bjp_cmp1 !== e.bjp_cmp1) value_error("disp_o.bjp_cmp1", e.bjp_cmp1, a.bjp_cmp1);
        if (a.bjp_cmp2 !== e.bjp_cmp2) value_error("disp_o.bjp_cmp2", e.bjp_cmp2, a.bjp_cmp2);
        if (a.bjp_tgt1 !== e.bjp_tgt1) value_error("disp_o.bjp_tgt1", e.bjp_tgt1, a.bjp_tgt1);
        if (a.bjp_tgt2 !== e.bjp_tgt2) value_error("disp_o.bjp_tgt2", e.bjp_tgt2, a.bjp_tgt2);
    endtask

    task automatic check_mem(input dispatch_pkg::disp_out_t e, input dispatch_pkg::disp_out_t a);
        if (a.mem_req !== e.mem_req) value_error("disp_o.mem_req", e.mem_req, a.mem_req);
        if (a.mem_op !== e.mem_op) value_error("disp_o.mem_op", e.mem_op, a.mem_op);
        if (a.mem_addr !== e.mem_addr) value_error("disp_o.mem_addr", e.mem_addr, a.mem_addr);
        if (a.mem_wmask !== e.mem_wmask) value_error("disp_o.mem_wmask", e.mem_wmask, a.mem_wmask);
        if (a.mem_wdata !== e.mem_wdata) value_error("disp_o.mem_wdata", e.mem_wdata, a.mem_wdata);
        if (a.misaligned_load !== e.misaligned_load)
            value_error("disp_o.misaligned_load", e.misaligned_load, a.misaligned_load);
        if (a.misaligned_store !== e.misaligned_store)
            value_error("disp_o.misaligned_store", e.misaligned_store, a.misaligned_store);
    endtask

    task automatic load_cases();
        int                      fd;
        int                      n;
        string                   ln;
        logic [31:0]             f [NUM_FIELDS];
        dispatch_pkg::disp_in_t  stim;
        dispatch_pkg::disp_out_t e;
        fd = $fopen("test/dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/dispatch_cases.txt");
            stop_run();
        end
        while ($fgets(ln, fd) != 0) begin
            if (ln.len() < 2 || ln[0] == "#")
                continue;  // Blank or column note
            n = $sscanf(ln, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                        f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                        f[22], f[23]);
            if (n != NUM_FIELDS) begin
                $display("Case line has %0d fields instead of %0d: %s", n, NUM_FIELDS, ln);
                stop_run();
            end
            stim.grp      = dispatch_pkg::disp_grp_e'(f[0][1:0]);
            stim.sub_op   = f[1][3:0];
            stim.op2_imm  = f[2][0];
            stim.pc       = f[3];
            stim.imm      = f[4];
            stim.rs1_data = f[5];
            stim.rs2_data = f[6];
            e.alu_req          = f[7][0];
            e.alu_op           = dispatch_pkg::alu_op_e'(f[8][3:0]);
            e.alu_op1          = f[9];
            e.alu_op2          = f[10];
            e.bjp_req          = f[11][0];
            e.bjp_op           = dispatch_pkg::bjp_op_e'(f[12][2:0]);
            e.bjp_cmp1         = f[13];
            e.bjp_cmp2         = f[14];
            e.bjp_tgt1         = f[15];
            e.bjp_tgt2         = f[16];
            e.mem_req          = f[17][0];
            e.mem_op           = dispatch_pkg::mem_op_e'(f[18][2:0]);
            e.mem_addr         = f[19];
            e.mem_wmask        = f[20][3:0];
            e.mem_wdata        = f[21];
            e.misaligned_load  = f[22][0];
            e.misaligned_store = f[23][0];
            stim_q.push_back(stim);
            exp_q.push_back(e);
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("The case file holds no cases");
            stop_run();
        end
    endtask

    // Upstream decoder side of the four-phase cycle
    task automatic run_driver();
        int unsigned cnt;
        foreach (stim_q[i]) begin
            repeat (random_bits(2)) @(posedge clk);
            @(posedge clk);
            req    <= 1'b1;
            in_pkt <= stim_q[i];
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_error("ack_o did not rise");
            end while (ack !== 1'b1);
            req <= 1'b0;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_error("ack_o did not fall");
            end while (ack !== 1'b0);
        end
    endtask

    // Execution unit side, random ack delay of 0 to 7 cycles
    task automatic run_responder();
        int unsigned             cnt;
        dispatch_pkg::disp_out_t e;
        while (exp_q.size() != 0) begin
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_error("disp_req_o did not rise");
            end while (disp_req !== 1'b1);
            e = exp_q.pop_front();
            check_alu(e, disp_pkt);
            check_bjp(e, disp_pkt);
            check_mem(e, disp_pkt);
            case_idx++;
            repeat (random_bits(3)) @(posedge clk);
            disp_ack <= 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_error("disp_req_o did not fall");
            end while (disp_req !== 1'b0);
            disp_ack <= 1'b0;
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        in_pkt     = '0;
        disp_ack   = 1'b0;
        case_idx   = 0;
        lfsr_state = 32'h6ccc5ffb;
        load_cases();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (ack !== 1'b0) value_error("ack_o", 32'd0, ack);
        if (disp_req !== 1'b0) value_error("disp_req_o", 32'd0, disp_req);
        fork
            run_driver();
            run_responder();
        join
        // Quiet window, one request per case and no more
        repeat (20) begin
            @(posedge clk);
            if (disp_req !== 1'b0) begin
                $display("Extra downstream request after the last case");
                stop_run();
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== test/dispatch_cases.txt ====
# in: grp sub_op op2_imm pc imm rs1 rs2  alu: req op op1 op2  bjp: req op cmp1 cmp2 tgt1 tgt2
# mem: req op addr wmask wdata misaligned_load misaligned_store (all fields hex)
0 0 0 100 0 12345678 11111111  1 0 12345678 11111111  0 0 0 0 0 0  0 0 0 0 0 0 0
0 1 1 104 fffffff0 20 99  1 1 20 fffffff0  0 0 0 0 0 0  0 0 0 0 0 0 0
0 7 1 108 1f f0000000 3  1 7 f0000000 1f  0 0 0 0 0 0  0 0 0 0 0 0 0
0 b 1 2000 12345000 dead beef  1 b 2000 12345000  0 0 0 0 0 0  0 0 0 0 0 0 0
0 a 1 2004 abcde000 dead beef  1 a 0 abcde000  0 0 0 0 0 0  0 0 0 0 0 0 0
1 0 1 3000 40 55 55  0 0 0 0  1 0 55 55 3000 40  0 0 0 0 0 0 0
1 4 0 3004 fffffff8 1 2  0 0 0 0  1 4 1 2 3004 fffffff8  0 0 0 0 0 0 0
1 6 0 3008 800 aa bb  1 c 3008 4  1 6 aa bb 3008 800  0 0 0 0 0 0 0
1 7 0 300c 10 4000 cc  1 c 300c 4  1 7 4000 cc 4000 10  0 0 0 0 0 0 0
2 5 0 0 10 1000 11223344  0 0 0 0  0 0 0 0 0 0  1 5 1010 1 44 0 0
2 5 0 0 11 1000 11223344  0 0 0 0  0 0 0 0 0 0  1 5 1011 2 4400 0 0
2 5 0 0 12 1000 11223344  0 0 0 0  0 0 0 0 0 0  1 5 1012 4 440000 0 0
2 5 0 0 13 1000 11223344  0 0 0 0  0 0 0 0 0 0  1 5 1013 8 44000000 0 0
2 6 0 0 0 2000 a1b2c3d4  0 0 0 0  0 0 0 0 0 0  1 6 2000 3 c3d4 0 0
2 6 0 0 1 2000 a1b2c3d4  0 0 0 0  0 0 0 0 0 0  1 6 2001 3 c3d4 0 1
2 6 0 0 2 2000 a1b2c3d4  0 0 0 0  0 0 0 0 0 0  1 6 2002 c c3d40000 0 0
2 6 0 0 3 2000 a1b2c3d4  0 0 0 0  0 0 0 0 0 0  1 6 2003 c c3d40000 0 1
2 7 0 0 4 3000 cafef00d  0 0 0 0  0 0 0 0 0 0  1 7 3004 f cafef00d 0 0
2 7 0 0 5 3000 cafef00d  0 0 0 0  0 0 0 0 0 0  1 7 3005 f cafef00d 0 1
2 7 0 0 6 3000 cafef00d  0 0 0 0  0 0 0 0 0 0  1 7 3006 f cafef00d 0 1
2 7 0 0 7 3000 cafef00d  0 0 0 0  0 0 0 0 0 0  1 7 3007 f cafef00d 0 1
2 2 0 0 8 4000 ffffffff  0 0 0 0  0 0 0 0 0 0  1 2 4008 0 0 0 0
2 2 0 0 a 4000 ffffffff  0 0 0 0  0 0 0 0 0 0  1 2 400a 0 0 1 0
2 1 0 0 1 4000 ffffffff  0 0 0 0  0 0 0 0 0 0  1 1 4001 0 0 1 0
2 4 0 0 3 4000 ffffffff  0 0 0 0  0 0 0 0 0 0  1 4 4003 0 0 1 0
2 0 0 0 3 4000 ffffffff  0 0 0 0  0 0 0 0 0 0  1 0 4003 0 0 0 0
2 3 0 0 fffffffd 4004 ffffffff  0 0 0 0  0 0 0 0 0 0  1 3 4001 0 0 0 0
3 0 1 5000 20 aaaa bbbb  0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0

// ==== list.f ====
rtl/dispatch_pkg.sv
rtl/req_ack_rx.sv
rtl/req_ack_tx.sv
rtl/operand_select.sv
rtl/store_align.sv
rtl/dispatch_top.sv
test/tb_dispatch.sv

// ==== Bender.yml ====
package:
  name: dispatch

sources:
  # RTL in compile order
  - files:
      - rtl/dispatch_pkg.sv
      - rtl/req_ack_rx.sv
      - rtl/req_ack_tx.sv
      - rtl/operand_select.sv
      - rtl/store_align.sv
      - rtl/dispatch_top.sv

  # Testbench
  - target: test
    files:
      - test/tb_dispatch.sv
